// File: all.f
+incdir+include
logic/exec_pkg.sv
logic/exec_lane_if.sv
logic/exec_rob_if.sv
logic/issue_unit.sv
logic/exec_lane.sv
logic/commit_unit.sv
logic/exec_core.sv
test/tb_exec_core.sv

// File: Bender.yml
package:
  name: exec_core

export_include_dirs:
  - include

sources:
  - files:
      - logic/exec_pkg.sv
      - logic/exec_lane_if.sv
      - logic/exec_rob_if.sv
      - logic/issue_unit.sv
      - logic/exec_lane.sv
      - logic/commit_unit.sv
      - logic/exec_core.sv
  - target: test
    files:
      - test/tb_exec_core.sv

// File: test/tb_exec_core.sv
// Testbench for exec_core with clock, reset and LCG stimulus
// Reference queue of expected commits and checking assertions

`default_nettype none

module tb_exec_core;

    localparam int WAIT_LIMIT = 200;

    logic                 clk_i = 1'b0;
    logic                 rst_ni;
    logic                 fetch_enable_i;
    logic                 in_valid_i;
    exec_pkg::exec_op_e   in_op_i;
    exec_pkg::xlen_t      in_a_i;
    exec_pkg::xlen_t      in_b_i;
    exec_pkg::reg_addr_t  in_rd_i;
    logic                 in_ready_o;
    logic                 commit_valid_o;
    exec_pkg::reg_addr_t  commit_rd_o;
    exec_pkg::xlen_t      commit_data_o;
    logic                 core_busy_o;

    // Expected commits oldest first and a mirror of the front entry
    exec_pkg::reg_addr_t  ref_rd_q [$];
    exec_pkg::xlen_t      ref_data_q [$];
    int                   ref_cnt = 0;
    exec_pkg::reg_addr_t  exp_rd = '0;
    exec_pkg::xlen_t      exp_data = '0;

    logic [31:0] lcg_state = 32'ha70f;
    int          n_errors = 0;
    int          n_accepted = 0;
    int          n_commits = 0;
    logic        timed_out = 1'b0;
    logic        in_reset_win = 1'b1;
    logic        gate_off = 1'b0;
    logic        stall_seen = 1'b0;

    exec_core dut0 (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .fetch_enable_i ( fetch_enable_i ),
        .in_valid_i     ( in_valid_i     ),
        .in_op_i        ( in_op_i        ),
        .in_a_i         ( in_a_i         ),
        .in_b_i         ( in_b_i         ),
        .in_rd_i        ( in_rd_i        ),
        .in_ready_o     ( in_ready_o     ),
        .commit_valid_o ( commit_valid_o ),
        .commit_rd_o    ( commit_rd_o    ),
        .commit_data_o  ( commit_data_o  ),
        .core_busy_o    ( core_busy_o    )
    );

    always #4 clk_i = ~clk_i;

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected result per opcode rule
    function automatic exec_pkg::xlen_t expect_result(exec_pkg::exec_op_e op,
                                                      exec_pkg::xlen_t a,
                                                      exec_pkg::xlen_t b);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        case (op)
            exec_pkg::OP_ADD: return a + b;
            exec_pkg::OP_SUB: return a - b;
            exec_pkg::OP_AND: return a & b;
            exec_pkg::OP_OR:  return a | b;
            exec_pkg::OP_XOR: return a ^ b;
            exec_pkg::OP_SLL: return a << b[4:0];
            default:          return prod[31:0];
        endcase
    endfunction

    task report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        n_errors++;
        $display("Fail %s exp %h got %h", name, exp, got);
    endtask

    task report_problem(input string msg);
        n_errors++;
        $display("Error: %s", msg);
    endtask

    task finish_test(input string name);
        $display("%s finished, %0d errors so far", name, n_errors);
    endtask

    // ------------------------------------------------------------
    // Reference model of accepted and retired operations
    // ------------------------------------------------------------
    always @(posedge clk_i) begin
        if (commit_valid_o) begin
            n_commits++;
            if (ref_data_q.size() != 0) begin
                void'(ref_rd_q.pop_front());
                void'(ref_data_q.pop_front());
            end
        end
        if (rst_ni && in_valid_i && !in_ready_o) begin
            stall_seen = 1'b1;
        end
        if (rst_ni && in_valid_i && in_ready_o) begin
            n_accepted++;
            ref_rd_q.push_back(in_rd_i);
            ref_data_q.push_back(expect_result(in_op_i, in_a_i, in_b_i));
        end
        ref_cnt = ref_data_q.size();
        if (ref_cnt != 0) begin
            exp_rd   = ref_rd_q[0];
            exp_data = ref_data_q[0];
        end
    end

    // ------------------------------------------------------------
    // Checks sampled mid-cycle
    // ------------------------------------------------------------
    a_reset_idle: assert property (@(negedge clk_i)
        in_reset_win |-> !(in_ready_o || commit_valid_o || core_busy_o))
        else report_problem("outputs not idle around reset");

    a_commit_known: assert property (@(negedge clk_i) disable iff (!rst_ni)
        commit_valid_o |-> (ref_cnt != 0))
        else report_problem("commit without an outstanding operation");

    a_commit_rd: assert property (@(negedge clk_i) disable iff (!rst_ni)
        (commit_valid_o && ref_cnt != 0) |-> (commit_rd_o == exp_rd))
        else report_mismatch("commit_rd_o", exp_rd, commit_rd_o);

    a_commit_data: assert property (@(negedge clk_i) disable iff (!rst_ni)
        (commit_valid_o && ref_cnt != 0) |-> (commit_data_o == exp_data))
        else report_mismatch("commit_data_o", exp_data, commit_data_o);

    a_core_busy: assert property (@(negedge clk_i) disable iff (!rst_ni)
        core_busy_o == (ref_cnt != 0))
        else report_mismatch("core_busy_o", 32'(ref_cnt != 0), 32'(core_busy_o));

    a_fetch_gate: assert property (@(negedge clk_i) gate_off |-> !in_ready_o)
        else report_mismatch("in_ready_o", 32'd0, 32'(in_ready_o));

    // Holds the operation until accepted and returns 1 unit after the edge
    task automatic send_op(input exec_pkg::exec_op_e op, input exec_pkg::xlen_t a,
                           input exec_pkg::xlen_t b, input exec_pkg::reg_addr_t rd);
        int   waited;
        logic taken;
        waited     = 0;
        taken      = 1'b0;
        in_valid_i = 1'b1;
        in_op_i    = op;
        in_a_i     = a;
        in_b_i     = b;
        in_rd_i    = rd;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            taken = in_ready_o;
            @(posedge clk_i);
            waited++;
        end
        #1;
        in_valid_i = 1'b0;
        if (!taken) begin
            report_problem("operation was not accepted in time");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk_i);
        while ((ref_cnt != 0 || core_busy_o) && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (ref_cnt != 0 || core_busy_o) begin
            report_problem("results did not drain in time");
            timed_out = 1'b1;
        end
        @(posedge clk_i);
        #1;
    endtask

    initial begin
        rst_ni         = 1'b0;
        fetch_enable_i = 1'b1;
        in_valid_i     = 1'b0;
        in_op_i        = exec_pkg::OP_ADD;
        in_a_i         = '0;
        in_b_i         = '0;
        in_rd_i        = '0;

        // Test 1 reset with fetch enable already high
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(posedge clk_i);
        #1;
        in_reset_win = 1'b0;
        finish_test("reset");

        // Test 2 each ALU opcode twice with random operands
        for (int i = 0; i < 12 && !timed_out; i++) begin
            send_op(exec_pkg::exec_op_e'(3'(i % 6)), next_rand(), next_rand(),
                    5'(i + 1));
        end
        if (!timed_out) wait_drain();
        finish_test("alu results");

        // Test 3 slow MUL first with younger ALU ops behind it
        if (!timed_out) begin
            send_op(exec_pkg::OP_MUL, next_rand(), next_rand(), 5'd20);
            send_op(exec_pkg::OP_ADD, next_rand(), next_rand(), 5'd21);
            send_op(exec_pkg::OP_XOR, next_rand(), next_rand(), 5'd22);
            send_op(exec_pkg::OP_SUB, next_rand(), next_rand(), 5'd23);
            wait_drain();
        end
        finish_test("multiply and ordering");

        // Test 4 MUL burst exhausts the lanes
        stall_seen = 1'b0;
        for (int i = 0; i < 10 && !timed_out; i++) begin
            send_op(exec_pkg::OP_MUL, next_rand(), next_rand(), 5'(i + 8));
        end
        if (!timed_out) wait_drain();
        assert (stall_seen) else report_problem("in_ready_o never dropped during the burst");
        finish_test("back-pressure");

        // Test 5 fetch gate closes while two products are in flight
        if (!timed_out) begin
            send_op(exec_pkg::OP_MUL, next_rand(), next_rand(), 5'd30);
            send_op(exec_pkg::OP_MUL, next_rand(), next_rand(), 5'd31);
            fetch_enable_i = 1'b0;
            @(posedge clk_i);
            #1;
            gate_off   = 1'b1;
            in_valid_i = 1'b1;
            in_op_i    = exec_pkg::OP_OR;
            repeat (6) @(posedge clk_i);
            #1;
            in_valid_i = 1'b0;
            wait_drain();
            gate_off = 1'b0;
        end
        assert (n_commits == n_accepted)
            else report_mismatch("commit count", n_accepted, n_commits);
        finish_test("fetch gate");

        $display("%0d accepted, %0d committed, %0d errors", n_accepted, n_commits, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/exec_core.sv
// Top level of the execution back end: fetch-enable register,
// issue unit, execution lanes and commit unit

`default_nettype none

`include "exec_defs.svh"

module exec_core (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 fetch_enable_i,
    // Operation stream
    input  wire logic                 in_valid_i,
    input  wire exec_pkg::exec_op_e   in_op_i,
    input  wire exec_pkg::xlen_t      in_a_i,
    input  wire exec_pkg::xlen_t      in_b_i,
    input  wire exec_pkg::reg_addr_t  in_rd_i,
    output logic                      in_ready_o,
    // Retired results
    output logic                      commit_valid_o,
    output exec_pkg::reg_addr_t       commit_rd_o,
    output exec_pkg::xlen_t           commit_data_o,
    output logic                      core_busy_o
);

    logic fetch_enable;

    exec_lane_if lane_bus [`EXEC_NR_LANES] ();
    exec_rob_if  rob_bus ();

    // ------------------------------------------------------------
    // Issue
    // ------------------------------------------------------------
    issue_unit i_issue_unit (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .fetch_enable_i ( fetch_enable   ),
        .in_valid_i     ( in_valid_i     ),
        .in_op_i        ( in_op_i        ),
        .in_a_i         ( in_a_i         ),
        .in_b_i         ( in_b_i         ),
        .in_rd_i        ( in_rd_i        ),
        .in_ready_o     ( in_ready_o     ),
        .core_busy_o    ( core_busy_o    ),
        .lanes          ( lane_bus       ),
        .rob            ( rob_bus        )
    );

    // ------------------------------------------------------------
    // Execution lanes
    // ------------------------------------------------------------
    for (genvar g = 0; g < `EXEC_NR_LANES; g++) begin : gen_lane
        exec_lane i_exec_lane (
            .clk_i  ( clk_i       ),
            .rst_ni ( rst_ni      ),
            .lane   ( lane_bus[g] )
        );
    end

    // ------------------------------------------------------------
    // Commit
    // ------------------------------------------------------------
    commit_unit i_commit_unit (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .lanes          ( lane_bus       ),
        .rob            ( rob_bus        ),
        .commit_valid_o ( commit_valid_o ),
        .commit_rd_o    ( commit_rd_o    ),
        .commit_data_o  ( commit_data_o  )
    );

    // Fetch enable takes effect one cycle late
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fetch_enable <= 1'b0;
        end else begin
            fetch_enable <= fetch_enable_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/commit_unit.sv
// Commit unit: reorder buffer that collects lane results
// and retires them in issue order, one per cycle

`default_nettype none

`include "exec_defs.svh"

module commit_unit (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    exec_lane_if.commit   lanes [`EXEC_NR_LANES],
    exec_rob_if.commit    rob,
    output logic                 commit_valid_o,
    output exec_pkg::reg_addr_t  commit_rd_o,
    output exec_pkg::xlen_t      commit_data_o
);

    // Writeback ports gathered into plain arrays
    logic                      wb_valid [`EXEC_NR_LANES];
    exec_pkg::trans_id_t       wb_id    [`EXEC_NR_LANES];
    exec_pkg::xlen_t           wb_data  [`EXEC_NR_LANES];

    // Reorder buffer
    logic [`EXEC_NR_SB_ENTRIES-1:0] done_q;
    exec_pkg::reg_addr_t       rd_q   [`EXEC_NR_SB_ENTRIES];
    exec_pkg::xlen_t           data_q [`EXEC_NR_SB_ENTRIES];

    exec_pkg::trans_id_t       head_q;
    logic                      retire_en;

    logic                      commit_valid_q;
    exec_pkg::reg_addr_t       commit_rd_q;
    exec_pkg::xlen_t           commit_data_q;

    for (genvar g = 0; g < `EXEC_NR_LANES; g++) begin : gen_wb
        assign wb_valid[g] = lanes[g].wb_valid;
        assign wb_id[g]    = lanes[g].wb_id;
        assign wb_data[g]  = lanes[g].wb_data;
    end

    // Oldest entry leaves as soon as its result is in
    assign retire_en = done_q[head_q];

    assign commit_valid_o = commit_valid_q;
    assign commit_rd_o    = commit_rd_q;
    assign commit_data_o  = commit_data_q;

    // Window slot is released with the visible commit
    assign rob.retire = commit_valid_q;

    // ------------------------------------------------------------
    // Done flags, head pointer and commit strobe
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            done_q         <= '0;
            head_q         <= '0;
            commit_valid_q <= 1'b0;
        end else begin
            for (int l = 0; l < `EXEC_NR_LANES; l++) begin
                if (wb_valid[l]) begin
                    done_q[wb_id[l]] <= 1'b1;
                end
            end
            // Head never collides with a pending writeback
            if (retire_en) begin
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            commit_valid_q <= retire_en;
        end
    end

    // ------------------------------------------------------------
    // Entry payload and commit data
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rob.alloc_valid) begin
            rd_q[rob.alloc_id] <= rob.alloc_rd;
        end
        for (int l = 0; l < `EXEC_NR_LANES; l++) begin
            if (wb_valid[l]) begin
                data_q[wb_id[l]] <= wb_data[l];
            end
        end
        if (retire_en) begin
            commit_rd_q   <= rd_q[head_q];
            commit_data_q <= data_q[head_q];
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_lane.sv
// Execution lane with a single-cycle ALU and an
// iterative shift-and-add multiplier

`default_nettype none

`include "exec_defs.svh"

module exec_lane (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    exec_lane_if.lane  lane
);

    localparam int unsigned MUL_STEPS = `EXEC_XLEN / `EXEC_MUL_BITS;
    localparam int unsigned STEP_W    = $clog2(MUL_STEPS);
    localparam int unsigned SHAMT_W   = $clog2(`EXEC_XLEN);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(MUL_STEPS - 1);

    exec_pkg::lane_state_e state_q, state_d;
    logic [STEP_W-1:0]     step_q;
    logic                  dispatch;

    exec_pkg::trans_id_t   id_q;
    exec_pkg::xlen_t       res_q;
    exec_pkg::xlen_t       mcand_q;
    exec_pkg::xlen_t       mplier_q;

    function automatic exec_pkg::xlen_t alu_result(exec_pkg::exec_op_e op,
                                                   exec_pkg::xlen_t a,
                                                   exec_pkg::xlen_t b);
        case (op)
            exec_pkg::OP_ADD: return a + b;
            exec_pkg::OP_SUB: return a - b;
            exec_pkg::OP_AND: return a & b;
            exec_pkg::OP_OR:  return a | b;
            exec_pkg::OP_XOR: return a ^ b;
            exec_pkg::OP_SLL: return a << b[SHAMT_W-1:0];
            default:          return '0;
        endcase
    endfunction

    // Partial product of one multiplier chunk, low bits only
    function automatic exec_pkg::xlen_t mul_step(exec_pkg::xlen_t mcand,
                                                 logic [`EXEC_MUL_BITS-1:0] bits);
        exec_pkg::xlen_t sum;
        sum = '0;
        for (int i = 0; i < `EXEC_MUL_BITS; i++) begin
            if (bits[i]) begin
                sum = sum + (mcand << i);
            end
        end
        return sum;
    endfunction

    assign dispatch = lane.disp_valid && !lane.busy;

    assign lane.busy     = (state_q == exec_pkg::LANE_MUL);
    assign lane.wb_valid = (state_q == exec_pkg::LANE_ALU);
    assign lane.wb_id    = id_q;
    assign lane.wb_data  = res_q;

    // ------------------------------------------------------------
    // Lane FSM
    // ------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            exec_pkg::LANE_IDLE, exec_pkg::LANE_ALU: begin
                if (dispatch) begin
                    state_d = (lane.disp_op == exec_pkg::OP_MUL) ? exec_pkg::LANE_MUL
                                                                 : exec_pkg::LANE_ALU;
                end else begin
                    state_d = exec_pkg::LANE_IDLE;
                end
            end
            // Product is ready after the last step
            exec_pkg::LANE_MUL: begin
                if (step_q == LAST_STEP) begin
                    state_d = exec_pkg::LANE_ALU;
                end
            end
            default: state_d = exec_pkg::LANE_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= exec_pkg::LANE_IDLE;
            step_q  <= '0;
        end else begin
            state_q <= state_d;
            if (dispatch) begin
                step_q <= '0;
            end else if (state_q == exec_pkg::LANE_MUL) begin
                step_q <= step_q + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (dispatch) begin
            id_q <= lane.disp_id;
            if (lane.disp_op == exec_pkg::OP_MUL) begin
                res_q    <= '0;
                mcand_q  <= lane.disp_a;
                mplier_q <= lane.disp_b;
            end else begin
                res_q <= alu_result(lane.disp_op, lane.disp_a, lane.disp_b);
            end
        end else if (state_q == exec_pkg::LANE_MUL) begin
            // Consume the low multiplier chunk
            res_q    <= res_q + mul_step(mcand_q, mplier_q[`EXEC_MUL_BITS-1:0]);
            mcand_q  <= mcand_q << `EXEC_MUL_BITS;
            mplier_q <= mplier_q >> `EXEC_MUL_BITS;
        end
    end

endmodule

`default_nettype wire

// File: logic/issue_unit.sv
// Issue unit: accepts operations, allocates reorder ids
// and dispatches to the lowest free lane

`default_nettype none

`include "exec_defs.svh"

module issue_unit (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 fetch_enable_i,
    input  wire logic                 in_valid_i,
    input  wire exec_pkg::exec_op_e   in_op_i,
    input  wire exec_pkg::xlen_t      in_a_i,
    input  wire exec_pkg::xlen_t      in_b_i,
    input  wire exec_pkg::reg_addr_t  in_rd_i,
    output logic                      in_ready_o,
    output logic                      core_busy_o,
    exec_lane_if.issue                lanes [`EXEC_NR_LANES],
    exec_rob_if.issue                 rob
);

    localparam int unsigned CNT_W = `EXEC_TRANS_ID_BITS + 1;
    localparam logic [CNT_W-1:0] WIN_DEPTH = CNT_W'(`EXEC_NR_SB_ENTRIES);

    logic [`EXEC_NR_LANES-1:0] lane_busy;
    logic                      free_found;
    exec_pkg::lane_sel_t       free_sel;
    logic                      accept;

    exec_pkg::trans_id_t       tail_q;
    logic [CNT_W-1:0]          count_q;

    // ------------------------------------------------------------
    // Lane selection
    // ------------------------------------------------------------
    // Scan downwards so the lowest free lane wins
    always_comb begin
        free_found = 1'b0;
        free_sel   = '0;
        for (int i = `EXEC_NR_LANES - 1; i >= 0; i--) begin
            if (!lane_busy[i]) begin
                free_found = 1'b1;
                free_sel   = exec_pkg::lane_sel_t'(i);
            end
        end
    end

    assign in_ready_o  = fetch_enable_i && (count_q < WIN_DEPTH) && free_found;
    assign accept      = in_valid_i && in_ready_o;
    assign core_busy_o = (count_q != '0);

    // ------------------------------------------------------------
    // Dispatch to the lanes
    // ------------------------------------------------------------
    for (genvar g = 0; g < `EXEC_NR_LANES; g++) begin : gen_disp
        assign lane_busy[g]        = lanes[g].busy;
        assign lanes[g].disp_valid = accept && (free_sel == exec_pkg::lane_sel_t'(g));
        assign lanes[g].disp_op    = in_op_i;
        assign lanes[g].disp_a     = in_a_i;
        assign lanes[g].disp_b     = in_b_i;
        assign lanes[g].disp_id    = tail_q;
    end

    // Reorder entry takes rd at the same edge as the dispatch
    assign rob.alloc_valid = accept;
    assign rob.alloc_id    = tail_q;
    assign rob.alloc_rd    = in_rd_i;

    // ------------------------------------------------------------
    // Tail pointer and window occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (accept) begin
                tail_q <= tail_q + 1'b1;
            end
            // Accept and retire in one cycle cancel out
            case ({accept, rob.retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_rob_if.sv
// Allocation and retire events between issue and commit

`default_nettype none

interface exec_rob_if;

    // New entry written at the tail
    logic                 alloc_valid;
    exec_pkg::trans_id_t  alloc_id;
    exec_pkg::reg_addr_t  alloc_rd;

    // One pulse per retired entry
    logic                 retire;

    modport issue (output alloc_valid, alloc_id, alloc_rd, input retire);

    modport commit (input alloc_valid, alloc_id, alloc_rd, output retire);

endinterface

`default_nettype wire

// File: logic/exec_lane_if.sv
// Dispatch and writeback bundle of one execution lane

`default_nettype none

interface exec_lane_if;

    // Dispatch from the issue unit
    logic                 disp_valid;
    exec_pkg::exec_op_e   disp_op;
    exec_pkg::xlen_t      disp_a;
    exec_pkg::xlen_t      disp_b;
    exec_pkg::trans_id_t  disp_id;

    // Lane status and writeback
    logic                 busy;
    logic                 wb_valid;
    exec_pkg::trans_id_t  wb_id;
    exec_pkg::xlen_t      wb_data;

    modport issue (output disp_valid, disp_op, disp_a, disp_b, disp_id, input busy);

    modport lane (
        input  disp_valid, disp_op, disp_a, disp_b, disp_id,
        output busy, wb_valid, wb_id, wb_data
    );

    modport commit (input wb_valid, wb_id, wb_data);

endinterface

`default_nettype wire

// File: logic/exec_pkg.sv
// Shared vector types and enums of the execution back end

`default_nettype none

`include "exec_defs.svh"

package exec_pkg;

    // Operand or result word
    typedef logic [`EXEC_XLEN-1:0] xlen_t;

    // Reorder window entry index
    typedef logic [`EXEC_TRANS_ID_BITS-1:0] trans_id_t;

    // Destination register number
    typedef logic [4:0] reg_addr_t;

    // Lane index
    typedef logic [1:0] lane_sel_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_MUL
    } exec_op_e;

    // LANE_ALU also marks the cycle a result is presented
    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_ALU,
        LANE_MUL
    } lane_state_e;

endpackage

`default_nettype wire

// File: include/exec_defs.svh
// Width, lane count and reorder window depth macros
// for the out-of-order execution back end

`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Operand and result width
`define EXEC_XLEN 32

// Identical execution lanes
`define EXEC_NR_LANES 3

// Reorder window depth, must stay a power of two
`define EXEC_NR_SB_ENTRIES 8

// Index width into the reorder window
`define EXEC_TRANS_ID_BITS 3

// Multiplier bits consumed per multiply step
`define EXEC_MUL_BITS 8

`endif
